/* all.f */
common/if_pkg.sv
design/fetch_pc_mux.sv
prefetch/prefetch_fifo.sv
prefetch/prefetch_buffer.sv
design/if_id_reg.sv
design/if_stage.sv
test/tb_instr_mem.sv
test/tb_if_stage.sv

/* common/if_pkg.sv */
/* fetch stage shared definitions
   widths, selector encodings, fetch entry and CSR bundles, debug addresses */
package if_pkg;

  localparam int unsigned XLEN        = 32;
  localparam int unsigned IRQ_ID_W    = 5;
  // low bits cleared in boot and trap vector bases
  localparam int unsigned VEC_ALIGN_W = 8;
  localparam int unsigned INSTR_BYTES = 4;

  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  typedef struct packed {
    logic                irq;
    logic [IRQ_ID_W-1:0] irq_id;
  } exc_cause_t;

  // one fetched word as it moves from the bus to ID
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic            err;
  } fetch_entry_t;

  typedef struct packed {
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] depc;
  } csr_pc_t;

endpackage

/* design/fetch_pc_mux.sv */
/* next fetch address select
   boot, jump, trap vectors, debug entry and returns, plus mtvec init on boot */
`timescale 1ns/1ps

module fetch_pc_mux #(
  parameter logic [if_pkg::XLEN-1:0] DmHaltAddr      = if_pkg::DM_HALT_ADDR,
  parameter logic [if_pkg::XLEN-1:0] DmExceptionAddr = if_pkg::DM_EXC_ADDR
) (
  input  logic [if_pkg::XLEN-1:0] boot_addr_i,
  input  if_pkg::pc_sel_e         pc_mux_i,
  input  if_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  if_pkg::exc_cause_t      exc_cause_i,
  input  logic [if_pkg::XLEN-1:0] branch_target_i,
  input  if_pkg::csr_pc_t         csr_i,
  input  logic                    pc_set_i,
  output logic [if_pkg::XLEN-1:0] fetch_addr_o,
  output logic                    csr_mtvec_init_o
);

  localparam int unsigned AW = if_pkg::XLEN;
  localparam int unsigned VW = if_pkg::VEC_ALIGN_W;

  logic [AW-1:0] boot_base;
  logic [AW-1:0] mtvec_base;
  logic [AW-1:0] irq_offset;
  logic [AW-1:0] exc_pc;
  logic [AW-1:0] next_pc;

  assign boot_base  = {boot_addr_i[AW-1:VW], {VW{1'b0}}};
  assign mtvec_base = {csr_i.mtvec[AW-1:VW], {VW{1'b0}}};
  // vectored mode: one word per interrupt line
  assign irq_offset = AW'(exc_cause_i.irq_id) * AW'(if_pkg::INSTR_BYTES);

  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      if_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      if_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                exc_pc = mtvec_base;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_JUMP: next_pc = branch_target_i;
      if_pkg::PC_EXC:  next_pc = exc_pc;
      if_pkg::PC_ERET: next_pc = csr_i.mepc;
      if_pkg::PC_DRET: next_pc = csr_i.depc;
      default:         next_pc = boot_base;
    endcase
  end

  // word aligned fetch only
  assign fetch_addr_o = {next_pc[AW-1:2], 2'b00};

  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::PC_BOOT);

endmodule

/* design/if_id_reg.sv */
/* IF-ID pipeline register
   holds the instruction for ID and checks that sequential PCs step by one word */
`timescale 1ns/1ps

module if_id_reg (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_valid_i,
  input  if_pkg::fetch_entry_t    fetch_entry_i,
  input  logic                    id_in_ready_i,
  input  logic                    pc_set_i,
  input  logic                    instr_valid_clear_i,
  output logic                    fetch_ready_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic [if_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                    instr_fetch_err_o,
  output logic [if_pkg::XLEN-1:0] pc_id_o,
  output logic                    pc_mismatch_alert_o
);

  localparam int unsigned AW = if_pkg::XLEN;

  logic          xfer;
  logic          valid_d;
  logic          prev_seq_q;
  logic [AW-1:0] pc_expected;
  logic          pc_mismatch;

  assign fetch_ready_o = id_in_ready_i;
  assign xfer          = fetch_valid_i & id_in_ready_i;

  // an instruction taken with a redirect is stale, load it but keep it invalid
  assign valid_d = (xfer & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  assign pc_expected = pc_id_o + AW'(if_pkg::INSTR_BYTES);
  assign pc_mismatch = xfer & prev_seq_q & (fetch_entry_i.addr != pc_expected);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o    <= 1'b0;
      instr_new_id_o      <= 1'b0;
      prev_seq_q          <= 1'b0;
      pc_mismatch_alert_o <= 1'b0;
    end else begin
      instr_valid_id_o    <= valid_d;
      instr_new_id_o      <= xfer;
      // any redirect breaks the chain until the next accepted word
      prev_seq_q          <= (prev_seq_q | xfer) & ~pc_set_i;
      pc_mismatch_alert_o <= pc_mismatch;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      instr_rdata_id_o  <= fetch_entry_i.rdata;
      instr_fetch_err_o <= fetch_entry_i.err;
      pc_id_o           <= fetch_entry_i.addr;
    end
  end

endmodule

/* design/if_stage.sv */
/* instruction fetch stage top
   PC select, prefetch buffer and IF-ID register */
`timescale 1ns/1ps

module if_stage #(
  parameter logic [if_pkg::XLEN-1:0] DmHaltAddr      = if_pkg::DM_HALT_ADDR,
  parameter logic [if_pkg::XLEN-1:0] DmExceptionAddr = if_pkg::DM_EXC_ADDR,
  parameter int unsigned             FifoDepth       = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [if_pkg::XLEN-1:0] boot_addr_i,
  input  logic                    req_i,
  // instruction bus
  output logic                    instr_req_o,
  output logic [if_pkg::XLEN-1:0] instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                    instr_err_i,
  // control from ID
  input  logic                    pc_set_i,
  input  if_pkg::pc_sel_e         pc_mux_i,
  input  if_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  if_pkg::exc_cause_t      exc_cause_i,
  input  logic [if_pkg::XLEN-1:0] branch_target_i,
  input  if_pkg::csr_pc_t         csr_i,
  input  logic                    id_in_ready_i,
  input  logic                    instr_valid_clear_i,
  output logic [if_pkg::XLEN-1:0] pc_if_o,
  output logic                    csr_mtvec_init_o,
  output logic                    if_busy_o,
  // to ID
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic [if_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic                    instr_fetch_err_o,
  output logic [if_pkg::XLEN-1:0] pc_id_o,
  output logic                    pc_mismatch_alert_o
);

  logic [if_pkg::XLEN-1:0] fetch_addr_n;
  logic                    fetch_valid;
  logic                    fetch_ready;
  if_pkg::fetch_entry_t    fetch_entry;

  fetch_pc_mux #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_mux (
    .boot_addr_i      (boot_addr_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .branch_target_i  (branch_target_i),
    .csr_i            (csr_i),
    .pc_set_i         (pc_set_i),
    .fetch_addr_o     (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) u_prefetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .addr_i         (fetch_addr_n),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .entry_o        (fetch_entry),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  assign pc_if_o = fetch_entry.addr;

  if_id_reg u_if_id (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_entry_i       (fetch_entry),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

/* prefetch/prefetch_buffer.sv */
/* prefetch buffer
   instruction bus master, drops stale responses after a redirect, fills the FIFO */
`timescale 1ns/1ps

module prefetch_buffer #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    branch_i,
  input  logic [if_pkg::XLEN-1:0] addr_i,
  input  logic                    ready_i,
  output logic                    valid_o,
  output if_pkg::fetch_entry_t    entry_o,
  output logic                    busy_o,
  output logic                    instr_req_o,
  output logic [if_pkg::XLEN-1:0] instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                    instr_err_i
);

  localparam int unsigned AW   = if_pkg::XLEN;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(FifoDepth - 1);

  logic [AW-1:0]        aq_mem [FifoDepth];
  logic [PtrW-1:0]      aq_wr_q;
  logic [PtrW-1:0]      aq_rd_q;
  logic [CntW-1:0]      out_q;
  logic [CntW-1:0]      disc_q;
  logic [CntW-1:0]      disc_d;
  logic [CntW-1:0]      fifo_free;
  logic [CntW-1:0]      valid_out;
  logic [AW-1:0]        next_addr_q;
  logic [AW-1:0]        held_addr_q;
  logic [AW-1:0]        fresh_addr;
  logic                 hold_q;
  logic                 hold_disc_q;
  logic                 fresh;
  logic                 room;
  logic                 gnt;
  logic                 stale_gnt;
  logic                 rsp_keep;
  if_pkg::fetch_entry_t rsp_entry;

  // responses still expected for the current stream
  assign valid_out = out_q - disc_q;
  // a redirect empties the FIFO, so room is guaranteed
  assign room      = branch_i | (fifo_free > valid_out);

  assign fresh_addr   = branch_i ? addr_i : next_addr_q;
  assign fresh        = ~hold_q & req_i & room & (out_q < CntW'(FifoDepth));
  assign instr_req_o  = hold_q | fresh;
  assign instr_addr_o = hold_q ? held_addr_q : fresh_addr;
  assign gnt          = instr_req_o & instr_gnt_i;

  // a held request that was overtaken by a redirect is fetched and then dropped
  assign stale_gnt = gnt & hold_q & (hold_disc_q | branch_i);
  assign rsp_keep  = instr_rvalid_i & ~branch_i & (disc_q == '0);

  always_comb begin
    if (branch_i) begin
      disc_d = out_q - CntW'(instr_rvalid_i);
    end else if (instr_rvalid_i && (disc_q != '0)) begin
      disc_d = disc_q - 1'b1;
    end else begin
      disc_d = disc_q;
    end
    disc_d = disc_d + CntW'(stale_gnt);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q       <= '0;
      disc_q      <= '0;
      hold_q      <= 1'b0;
      hold_disc_q <= 1'b0;
      next_addr_q <= '0;
      aq_wr_q     <= '0;
      aq_rd_q     <= '0;
    end else begin
      out_q       <= out_q + CntW'(gnt) - CntW'(instr_rvalid_i);
      disc_q      <= disc_d;
      hold_q      <= instr_req_o & ~instr_gnt_i;
      hold_disc_q <= hold_q & ~instr_gnt_i & (hold_disc_q | branch_i);
      // step as soon as a new request goes out, it is held until granted
      next_addr_q <= fresh ? fresh_addr + AW'(if_pkg::INSTR_BYTES) : fresh_addr;
      if (gnt) begin
        aq_wr_q <= (aq_wr_q == LastPtr) ? '0 : aq_wr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        aq_rd_q <= (aq_rd_q == LastPtr) ? '0 : aq_rd_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fresh) begin
      held_addr_q <= fresh_addr;
    end
    if (gnt) begin
      aq_mem[aq_wr_q] <= instr_addr_o;
    end
  end

  assign rsp_entry = '{rdata: instr_rdata_i, addr: aq_mem[aq_rd_q], err: instr_err_i};

  prefetch_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (branch_i),
    .in_valid_i  (rsp_keep),
    .in_entry_i  (rsp_entry),
    .out_ready_i (ready_i),
    .out_valid_o (valid_o),
    .out_entry_o (entry_o),
    .free_o      (fifo_free)
  );

  assign busy_o = hold_q | (out_q != '0);

  rvalid_needs_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> (out_q != '0));

  // bus rule: request and address stay put until granted
  req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)));

endmodule

/* prefetch/prefetch_fifo.sv */
/* prefetch FIFO
   circular buffer of fetched words with address and error flag */
`timescale 1ns/1ps

module prefetch_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               in_valid_i,
  input  if_pkg::fetch_entry_t               in_entry_i,
  input  logic                               out_ready_i,
  output logic                               out_valid_o,
  output if_pkg::fetch_entry_t               out_entry_o,
  output logic [$clog2(FifoDepth + 1)-1:0]   free_o
);

  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(FifoDepth - 1);

  if_pkg::fetch_entry_t mem [FifoDepth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  assign out_valid_o = (cnt_q != '0);
  assign out_entry_o = mem[rd_ptr_q];
  assign free_o      = CntW'(FifoDepth) - cnt_q;

  assign push = in_valid_i & ~clear_i;
  assign pop  = out_valid_o & out_ready_i & ~clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(push) - CntW'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= in_entry_i;
    end
  end

  // the issue rule upstream keeps a slot free for every expected response
  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (cnt_q < CntW'(FifoDepth)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_if_stage \
  -f all.f -o sim_if_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_if_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$log"; then
  exit 1
fi
exit 0

/* test/tb_if_stage.sv */
/* fetch stage testbench
   boot, jumps, traps and returns checked against a reference PC stream */
`timescale 1ns/1ps

module tb_if_stage;

  localparam logic [31:0] DmHalt     = 32'h1A11_0800;
  localparam logic [31:0] DmExc      = 32'h1A11_0808;
  localparam int unsigned Depth      = 2;
  localparam int unsigned HoldCycles = 5;
  // about 90 words at no worse than 16 cycles each, plus redirect gaps, rounded up with margin
  localparam int unsigned TimeoutCycles = 4000;

  logic                 clk_i;
  logic                 rst_ni;
  logic [31:0]          boot_addr_i;
  logic                 req_i;
  logic                 instr_req_o;
  logic [31:0]          instr_addr_o;
  logic                 instr_gnt_i;
  logic                 instr_rvalid_i;
  logic [31:0]          instr_rdata_i;
  logic                 instr_err_i;
  logic                 pc_set_i;
  if_pkg::pc_sel_e      pc_mux_i;
  if_pkg::exc_pc_sel_e  exc_pc_mux_i;
  if_pkg::exc_cause_t   exc_cause_i;
  logic [31:0]          branch_target_i;
  if_pkg::csr_pc_t      csr_i;
  logic                 id_in_ready_i;
  logic                 instr_valid_clear_i;
  logic [31:0]          pc_if_o;
  logic                 csr_mtvec_init_o;
  logic                 if_busy_o;
  logic                 instr_valid_id_o;
  logic                 instr_new_id_o;
  logic [31:0]          instr_rdata_id_o;
  logic                 instr_fetch_err_o;
  logic [31:0]          pc_id_o;
  logic                 pc_mismatch_alert_o;

  integer      seed = 32'h8e4a6965;
  int unsigned err_count = 0;
  int unsigned check_count = 0;
  int unsigned err_word_count = 0;
  int unsigned pend_count = 0;
  int unsigned cycle_count;
  logic        boot_req;
  logic        after_reset = 1'b0;
  logic [31:0] last_pc_if;
  logic [31:0] exp_q[$];

  if_stage #(
    .DmHaltAddr      (DmHalt),
    .DmExceptionAddr (DmExc),
    .FifoDepth       (Depth)
  ) u_dut (.*);

  tb_instr_mem u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // bit 32 is the error flag, the rest the instruction word
  function automatic logic [32:0] expected_word(input logic [31:0] addr);
    return {&addr[7:2], addr ^ 32'hA5A5_0000};
  endfunction

  function automatic logic [31:0] redirect_target(input if_pkg::pc_sel_e sel,
      input if_pkg::exc_pc_sel_e esel, input logic [4:0] irq_id, input logic [31:0] jump);
    logic [31:0] base;
    logic [31:0] t;
    base = {csr_i.mtvec[31:8], 8'h00};
    case (sel)
      if_pkg::PC_BOOT: t = {boot_addr_i[31:8], 8'h00};
      if_pkg::PC_JUMP: t = jump;
      if_pkg::PC_ERET: t = csr_i.mepc;
      if_pkg::PC_DRET: t = csr_i.depc;
      default: begin
        case (esel)
          if_pkg::EXC_PC_IRQ:     t = base + {25'd0, irq_id, 2'b00};
          if_pkg::EXC_PC_DBD:     t = DmHalt;
          if_pkg::EXC_PC_DBG_EXC: t = DmExc;
          default:                t = base;
        endcase
      end
    endcase
    t[1:0] = 2'b00;
    return t;
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic expect_low(input string name, input logic value);
    if (value !== 1'b0) show_mismatch(name, 32'd0, {31'd0, value});
  endtask

  task automatic note_failure(input string what);
    $display("%0t %s", $time, what);
    err_count++;
  endtask

  task automatic print_summary();
    $display("checks %0d, fetch error words %0d, errors %0d", check_count, err_word_count,
             err_count);
  endtask

  task automatic set_pc(input if_pkg::pc_sel_e sel, input if_pkg::exc_pc_sel_e esel,
      input logic [4:0] irq_id, input logic [31:0] target);
    pc_mux_i        <= sel;
    exc_pc_mux_i    <= esel;
    exc_cause_i     <= '{irq: (esel == if_pkg::EXC_PC_IRQ), irq_id: irq_id};
    branch_target_i <= target;
    pc_set_i        <= 1'b1;
    boot_req        <= (sel == if_pkg::PC_BOOT);
    req_i           <= 1'b1;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
    boot_req <= 1'b0;
  endtask

  // back-pressure drops ready about one cycle in four
  task automatic wait_words(input int unsigned n, input logic random_ready);
    int unsigned goal;
    goal = check_count + n;
    while (check_count < goal) begin
      @(posedge clk_i);
      if (random_ready) begin
        id_in_ready_i <= (($random(seed) & 3) != 0);
      end else begin
        id_in_ready_i <= 1'b1;
      end
    end
  endtask

  task automatic hold_in_id();
    logic [31:0] held_pc;
    id_in_ready_i       <= 1'b1;
    instr_valid_clear_i <= 1'b0;
    @(posedge clk_i);
    while (!instr_valid_id_o) @(posedge clk_i);
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    held_pc = pc_id_o;
    repeat (HoldCycles) begin
      @(posedge clk_i);
      if (!instr_valid_id_o) show_mismatch("instr_valid_id_o", 32'd1, 32'd0);
      if (pc_id_o !== held_pc) show_mismatch("pc_id_o", held_pc, pc_id_o);
    end
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    if (instr_valid_id_o) show_mismatch("instr_valid_id_o", 32'd0, 32'd1);
    id_in_ready_i <= 1'b1;
  endtask

  // compares what ID received in the cycle that just ended
  always @(posedge clk_i) begin
    logic [31:0] exp_pc;
    logic [32:0] exp_word;
    if (!rst_ni) begin
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        expect_low("instr_req_o", instr_req_o);
        expect_low("instr_valid_id_o", instr_valid_id_o);
        expect_low("instr_new_id_o", instr_new_id_o);
        expect_low("if_busy_o", if_busy_o);
        after_reset = 1'b0;
      end
      if (csr_mtvec_init_o !== boot_req) begin
        show_mismatch("csr_mtvec_init_o", {31'd0, boot_req}, {31'd0, csr_mtvec_init_o});
      end
      if (pc_mismatch_alert_o !== 1'b0) begin
        show_mismatch("pc_mismatch_alert_o", 32'd0, {31'd0, pc_mismatch_alert_o});
      end
      // a granted request counts until its response comes back
      if (pend_count != 0 && if_busy_o !== 1'b1) begin
        show_mismatch("if_busy_o", 32'd1, {31'd0, if_busy_o});
      end
      if (instr_req_o && instr_gnt_i) pend_count++;
      if (instr_rvalid_i) pend_count--;
      if (instr_valid_id_o && instr_new_id_o) begin
        if (exp_q.size() == 0) begin
          note_failure("an instruction reached ID before any fetch address was set");
        end else begin
          exp_pc   = exp_q.pop_front();
          exp_word = expected_word(exp_pc);
          check_count++;
          if (pc_id_o !== exp_pc) show_mismatch("pc_id_o", exp_pc, pc_id_o);
          // the word was offered on the fetch side one cycle earlier
          if (last_pc_if !== exp_pc) show_mismatch("pc_if_o", exp_pc, last_pc_if);
          if (instr_rdata_id_o !== exp_word[31:0]) begin
            show_mismatch("instr_rdata_id_o", exp_word[31:0], instr_rdata_id_o);
          end
          if (instr_fetch_err_o !== exp_word[32]) begin
            show_mismatch("instr_fetch_err_o", {31'd0, exp_word[32]}, {31'd0, instr_fetch_err_o});
          end
          if (exp_word[32]) err_word_count++;
          exp_q.push_back(exp_pc + 32'd4);
        end
      end
      // words fetched before a redirect never count again
      if (pc_set_i) begin
        exp_q.delete();
        exp_q.push_back(redirect_target(pc_mux_i, exc_pc_mux_i, exc_cause_i.irq_id,
                                        branch_target_i));
      end
      last_pc_if = pc_if_o;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("run did not complete within %0d cycles", TimeoutCycles);
    print_summary();
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    boot_req            = 1'b0;
    pc_mux_i            = if_pkg::PC_BOOT;
    exc_pc_mux_i        = if_pkg::EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_i     = '0;
    boot_addr_i         = 32'h1A2B_3CE7;
    csr_i               = '{mtvec: 32'h0000_3A45, mepc: 32'h0000_5128, depc: 32'h0000_6A30};
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    set_pc(if_pkg::PC_BOOT, if_pkg::EXC_PC_EXC, 5'd0, '0);
    wait_words(6, 1'b0);
    // 0x23fc sits on an error address
    set_pc(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 5'd0, 32'h0000_23F0);
    wait_words(8, 1'b0);
    set_pc(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 5'd0, 32'h0001_0100);
    wait_words(20, 1'b1);
    for (int i = 0; i < 4; i++) begin
      set_pc(if_pkg::PC_EXC, if_pkg::exc_pc_sel_e'(i[1:0]), 5'd13, '0);
      wait_words(6, 1'b1);
    end
    set_pc(if_pkg::PC_ERET, if_pkg::EXC_PC_EXC, 5'd0, '0);
    wait_words(6, 1'b1);
    set_pc(if_pkg::PC_DRET, if_pkg::EXC_PC_EXC, 5'd0, '0);
    wait_words(6, 1'b1);
    // two redirects in a row, only the second target survives
    set_pc(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 5'd0, 32'h0000_7700);
    set_pc(if_pkg::PC_JUMP, if_pkg::EXC_PC_EXC, 5'd0, 32'h0000_81F8);
    wait_words(6, 1'b1);
    hold_in_id();
    wait_words(4, 1'b0);
    // stop fetching and let the outstanding responses drain
    req_i <= 1'b0;
    @(posedge clk_i);
    while (if_busy_o) @(posedge clk_i);
    if (err_word_count == 0) note_failure("no word from an error address reached ID");
    print_summary();
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* test/tb_instr_mem.sv */
/* instruction memory model
   random grant and response delays, in-order responses, data derived from the address */
`timescale 1ns/1ps

module tb_instr_mem (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  integer      seed     = 32'h8e4a6965;
  int unsigned cyc      = 0;
  logic [1:0]  gnt_wait = 2'd0;
  logic        rvalid_q = 1'b0;
  logic [31:0] rdata_q  = '0;
  logic        err_q    = 1'b0;
  logic [31:0] rsp_addr;
  logic [31:0] addr_q[$];
  int unsigned due_q[$];

  // a zero wait grants in the same cycle as the request
  assign gnt_o    = req_i & (gnt_wait == 2'd0);
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_wait <= 2'd0;
      rvalid_q <= 1'b0;
      cyc = 0;
      addr_q.delete();
      due_q.delete();
    end else begin
      cyc = cyc + 1;
      if (gnt_o) begin
        addr_q.push_back(addr_i);
        // response lands 1 to 3 cycles after the grant
        due_q.push_back(cyc + (unsigned'($random(seed)) % 3));
        gnt_wait <= 2'(unsigned'($random(seed)) % 3);
      end else if (req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      rvalid_q <= 1'b0;
      // one response per cycle, always in grant order
      if (addr_q.size() > 0 && due_q[0] <= cyc) begin
        rsp_addr = addr_q.pop_front();
        void'(due_q.pop_front());
        rvalid_q <= 1'b1;
        rdata_q  <= rsp_addr ^ 32'hA5A5_0000;
        err_q    <= &rsp_addr[7:2];
      end
    end
  end

endmodule
